/* Bender.yml */
package:
  name: fir_wallace

sources:
  - include_dirs:
      - src
    files:
      - src/fir_pkg.sv
      - src/csa_stage.sv
      - src/csa_tree.sv
      - src/tap_line.sv
      - src/fir_accumulate.sv
      - src/fir_wallace.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/fir_wallace_tb.sv

/* fir_wallace.f */
+incdir+src
src/fir_pkg.sv
src/csa_stage.sv
src/csa_tree.sv
src/tap_line.sv
src/fir_accumulate.sv
src/fir_wallace.sv
tests/fir_wallace_tb.sv

/* src/csa_stage.sv */
// One layer of 3:2 carry-save compressors, chained by csa_tree to reduce n operands to two
`default_nettype none

module csa_stage #(
  parameter int OP_WIDTH    = 35,
  parameter int IN_OP_NUM   = 8,
  // Two words per full group plus the leftovers
  localparam int OUT_OP_NUM = 2 * (IN_OP_NUM / 3) + IN_OP_NUM % 3
) (
  input  wire logic [OP_WIDTH-1:0] in_op  [IN_OP_NUM],
  output logic      [OP_WIDTH-1:0] out_op [OUT_OP_NUM]
);

  // Full groups of three go through a compressor
  localparam int GROUPS = IN_OP_NUM / 3;
  // Zero, one or two operands left over
  localparam int REST = IN_OP_NUM % 3;

  //////////////////////////////////////////////////////////////////////
  // Compressors
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < GROUPS; g++) begin : comp_gen
    logic [OP_WIDTH-1:0] op_a;
    logic [OP_WIDTH-1:0] op_b;
    logic [OP_WIDTH-1:0] op_c;
    logic [OP_WIDTH-1:0] maj;

    assign op_a = in_op[3*g];
    assign op_b = in_op[3*g+1];
    assign op_c = in_op[3*g+2];

    // Bitwise majority is the carry out of each full adder
    assign maj = (op_a & op_b) | (op_a & op_c) | (op_b & op_c);

    // Sum word keeps its weight
    assign out_op[2*g] = op_a ^ op_b ^ op_c;
    // Carry word moves up one bit, top carry drops out (mod 2^OP_WIDTH)
    assign out_op[2*g+1] = {maj[OP_WIDTH-2:0], 1'b0};
  end

  //////////////////////////////////////////////////////////////////////
  // Leftover operands
  //////////////////////////////////////////////////////////////////////

  // Placed after the compressed words, unchanged
  for (genvar r = 0; r < REST; r++) begin : pass_gen
    assign out_op[2*GROUPS+r] = in_op[3*GROUPS+r];
  end

endmodule : csa_stage

`default_nettype wire

/* src/csa_tree.sv */
// Parameterized n-to-2 carry-save reduction tree built from csa_stage layers, combinational
`default_nettype none

module csa_tree #(
  parameter int OP_NUM   = 8,
  parameter int OP_WIDTH = 35
) (
  input  wire logic [OP_WIDTH-1:0] in_op  [OP_NUM],
  output logic      [OP_WIDTH-1:0] out_op [2]
);

  //////////////////////////////////////////////////////////////////////
  // Layer sizing at elaboration
  //////////////////////////////////////////////////////////////////////

  // Count layers until only two operands remain
  function automatic int stage_count();
    int n;
    int cnt;
    n = OP_NUM;
    cnt = 0;
    while (n > 2) begin
      n = 2 * (n / 3) + n % 3;
      cnt++;
    end
    return cnt;
  endfunction

  localparam int STAGE_NUM = stage_count();

  // Operand count entering each layer, last entry is the tree output
  typedef int op_count_t [STAGE_NUM+1];

  function automatic op_count_t op_count();
    op_count_t cnt;
    cnt[0] = OP_NUM;
    for (int s = 1; s <= STAGE_NUM; s++) begin
      cnt[s] = 2 * (cnt[s-1] / 3) + cnt[s-1] % 3;
    end
    return cnt;
  endfunction

  localparam op_count_t OP_NUM_STAGE = op_count();

  //////////////////////////////////////////////////////////////////////
  // Layer chain
  //////////////////////////////////////////////////////////////////////

  if (STAGE_NUM == 0) begin : bypass_gen
    // Two or fewer operands, nothing to compress
    assign out_op[0] = in_op[0];
    if (OP_NUM == 2) begin : pair_gen
      assign out_op[1] = in_op[1];
    end else begin : pad_gen
      assign out_op[1] = '0;
    end
  end else begin : tree_gen
    for (genvar s = 0; s < STAGE_NUM; s++) begin : layer_gen
      // Output words of this layer
      logic [OP_WIDTH-1:0] op_out [OP_NUM_STAGE[s+1]];

      if (s == 0) begin : first_gen
        csa_stage #(.OP_WIDTH(OP_WIDTH), .IN_OP_NUM(OP_NUM_STAGE[s])) u_csa_stage (
          .in_op  (in_op),
          .out_op (op_out)
        );
      end else begin : next_gen
        // Fed by the previous layer
        csa_stage #(.OP_WIDTH(OP_WIDTH), .IN_OP_NUM(OP_NUM_STAGE[s])) u_csa_stage (
          .in_op  (layer_gen[s-1].op_out),
          .out_op (op_out)
        );
      end
    end

    // Last layer always yields exactly two words
    assign out_op = layer_gen[STAGE_NUM-1].op_out;
  end

endmodule : csa_tree

`default_nettype wire

/* src/fir_accumulate.sv */
// Sign extension, CSA reduction, final addition and output handshake of the FIR datapath
`default_nettype none

`include "fir_config.svh"

module fir_accumulate (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               prod_req,
  output logic                    prod_ack,
  input  wire fir_pkg::product_t  prod     [`FIR_TAPS],
  output logic                    out_req,
  input  wire logic               out_ack,
  output fir_pkg::acc_t           out_data
);

  import fir_pkg::*;

  // Register free, result offered, waiting for out_ack low
  typedef enum logic [1:0] {ST_FREE, ST_SEND, ST_RELEASE} state_t;

  state_t           state;
  logic             capture;
  logic [ACC_W-1:0] ext_op [`FIR_TAPS];
  logic [ACC_W-1:0] sum_op [2];
  acc_t             sum;

  //////////////////////////////////////////////////////////////////////
  // Reduction and final adder
  //////////////////////////////////////////////////////////////////////

  // Sign extend each product to the accumulator width
  always_comb begin
    for (int k = 0; k < `FIR_TAPS; k++) begin
      ext_op[k] = acc_t'(prod[k]);
    end
  end

  csa_tree #(.OP_NUM(`FIR_TAPS), .OP_WIDTH(ACC_W)) u_csa_tree (
    .in_op  (ext_op),
    .out_op (sum_op)
  );

  // Single carry-propagate add, wraps exactly like the tree
  assign sum = sum_op[0] + sum_op[1];

  //////////////////////////////////////////////////////////////////////
  // Output register and handshakes
  //////////////////////////////////////////////////////////////////////

  // New products only into a free register, old ack must be gone
  assign capture = (state == ST_FREE) && prod_req && !prod_ack;

  always_ff @(posedge clk) begin
    if (capture) begin
      out_data <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_FREE;
      prod_ack <= 1'b0;
      out_req  <= 1'b0;
    end else begin
      // Product side: ack on capture, release when req falls
      if (capture) begin
        prod_ack <= 1'b1;
      end else if (!prod_req) begin
        prod_ack <= 1'b0;
      end
      // Output side
      case (state)
        ST_FREE: if (capture) begin
          out_req <= 1'b1;
          state   <= ST_SEND;
        end
        ST_SEND: if (out_ack) begin
          out_req <= 1'b0;
          state   <= ST_RELEASE;
        end
        ST_RELEASE: if (!out_ack) state <= ST_FREE;
        default: state <= ST_FREE;
      endcase
    end
  end

endmodule : fir_accumulate

`default_nettype wire

/* src/fir_config.svh */
// FIR size and width macros, included by the package and by every module that sizes tap arrays

`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Filter geometry
//////////////////////////////////////////////////////////////////////

// Number of filter taps, also the operand count of the CSA tree
`define FIR_TAPS 8

// Signed sample width on the input handshake
`define FIR_DATA_W 16

// Signed coefficient width of the static coefficient array
`define FIR_COEF_W 16

`endif

/* src/fir_pkg.sv */
// Shared FIR data types, imported by the tap line, the accumulator and the top level
`default_nettype none

`include "fir_config.svh"

package fir_pkg;

  // Full-precision product of one sample and one coefficient
  localparam int PROD_W = `FIR_DATA_W + `FIR_COEF_W;

  // Room for the sum of all taps at full scale, no overflow possible
  localparam int ACC_W = PROD_W + $clog2(`FIR_TAPS);

  // Input sample
  typedef logic signed [`FIR_DATA_W-1:0] sample_t;

  // Filter coefficient
  typedef logic signed [`FIR_COEF_W-1:0] coef_t;

  // Tap product before sign extension
  typedef logic signed [PROD_W-1:0] product_t;

  // Filter output and accumulator word
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage : fir_pkg

`default_nettype wire

/* src/fir_wallace.sv */
// Streaming FIR filter top with a Wallace-tree accumulator and req/ack handshakes on both sides
`default_nettype none

`include "fir_config.svh"

module fir_wallace (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // Static coefficients
  input  wire fir_pkg::coef_t    coef     [`FIR_TAPS],
  // Sample input handshake
  input  wire logic              in_req,
  output logic                   in_ack,
  input  wire fir_pkg::sample_t  in_data,
  // Filter output handshake
  output logic                   out_req,
  input  wire logic              out_ack,
  output fir_pkg::acc_t          out_data
);

  import fir_pkg::*;

  // Tap line to accumulator link
  logic     prod_req;
  logic     prod_ack;
  product_t prod [`FIR_TAPS];

  tap_line u_tap_line (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_data  (in_data),
    .coef     (coef),
    .prod_req (prod_req),
    .prod_ack (prod_ack),
    .prod     (prod)
  );

  fir_accumulate u_fir_accumulate (
    .clk      (clk),
    .rst_n    (rst_n),
    .prod_req (prod_req),
    .prod_ack (prod_ack),
    .prod     (prod),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

endmodule : fir_wallace

`default_nettype wire

/* src/tap_line.sv */
// Input req/ack handshake, sample delay line and registered tap products for the FIR datapath
`default_nettype none

`include "fir_config.svh"

module tap_line (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_req,
  output logic                   in_ack,
  input  wire fir_pkg::sample_t  in_data,
  input  wire fir_pkg::coef_t    coef     [`FIR_TAPS],
  output logic                   prod_req,
  input  wire logic              prod_ack,
  output fir_pkg::product_t      prod     [`FIR_TAPS]
);

  import fir_pkg::*;

  // Idle, products offered, input acknowledged, waiting for prod_ack low
  typedef enum logic [1:0] {ST_IDLE, ST_PROD, ST_ACK, ST_DRAIN} state_t;

  state_t   state;
  logic     accept;
  sample_t  taps      [`FIR_TAPS];
  sample_t  taps_next [`FIR_TAPS];
  product_t prod_next [`FIR_TAPS];

  //////////////////////////////////////////////////////////////////////
  // Delay line and products
  //////////////////////////////////////////////////////////////////////

  // Take a sample only from idle
  assign accept = (state == ST_IDLE) && in_req;

  // Tap 0 is the incoming sample, the rest shift by one
  always_comb begin
    taps_next[0] = in_data;
    for (int k = 1; k < `FIR_TAPS; k++) begin
      taps_next[k] = taps[k-1];
    end
    // All multiplies in parallel on the shifted line
    for (int k = 0; k < `FIR_TAPS; k++) begin
      prod_next[k] = taps_next[k] * coef[k];
    end
  end

  // History starts at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `FIR_TAPS; k++) begin
        taps[k] <= '0;
      end
    end else if (accept) begin
      taps <= taps_next;
    end
  end

  // Held stable for the whole product handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      prod <= prod_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      prod_req <= 1'b0;
      in_ack   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (accept) begin
          prod_req <= 1'b1;
          state    <= ST_PROD;
        end
        // Ack the source only once the accumulator has the products
        ST_PROD: if (prod_ack) begin
          prod_req <= 1'b0;
          in_ack   <= 1'b1;
          state    <= ST_ACK;
        end
        ST_ACK: if (!in_req) begin
          in_ack <= 1'b0;
          state  <= ST_DRAIN;
        end
        ST_DRAIN: if (!prod_ack) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : tap_line

`default_nettype wire

/* tests/fir_wallace_tb.sv */
// Self-checking testbench driving random samples and coefficients through the FIR against a convolution model
`default_nettype none

`include "fir_config.svh"

module fir_wallace_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fir_pkg::*;

  // Cycle limit of every handshake wait
  localparam int TIMEOUT = 200;

  logic    clk;
  logic    rst_n;
  coef_t   coef [`FIR_TAPS];
  logic    in_req;
  logic    in_ack;
  sample_t in_data;
  logic    out_req;
  logic    out_ack;
  acc_t    out_data;

  integer  seed = 32'h3cd7;
  int      out_count;
  string   test_name = "none";
  // Reference delay line with tap 0 as the newest sample
  sample_t model_taps [`FIR_TAPS];
  // Expected results in input order
  acc_t    exp_q [$];

  fir_wallace fir_wallace_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .coef     (coef),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_data  (in_data),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // Shift the reference line and return the convolution at accumulator width
  function automatic acc_t model_step(input sample_t s);
    longint sum;
    for (int k = `FIR_TAPS - 1; k > 0; k--) begin
      model_taps[k] = model_taps[k-1];
    end
    model_taps[0] = s;
    sum = 0;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      sum += longint'(model_taps[k]) * longint'(coef[k]);
    end
    return acc_t'(sum);
  endfunction

  // Random sample or one of the two full-scale extremes
  function automatic sample_t pick_sample(input bit full);
    sample_t lo;
    lo = '0;
    lo[`FIR_DATA_W-1] = 1'b1;
    if (!full) begin
      return sample_t'($random(seed));
    end
    return ($random(seed) & 1) ? lo : ~lo;
  endfunction

  task automatic draw_coefs(input bit full);
    coef_t lo;
    lo = '0;
    lo[`FIR_COEF_W-1] = 1'b1;
    @(posedge clk);
    for (int k = 0; k < `FIR_TAPS; k++) begin
      if (full) begin
        coef[k] <= ($random(seed) & 1) ? lo : ~lo;
      end else begin
        coef[k] <= coef_t'($random(seed));
      end
    end
    // One more edge so the model already sees the new coefficients
    @(posedge clk);
  endtask

  // Poll in_ack or out_req on each edge until it reaches the level
  task automatic wait_level(input bit on_output, input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      assert (cycles < TIMEOUT) else report_failure($sformatf(
        "Timeout in %s, %s never went to %0d", test_name,
        on_output ? "out_req" : "in_ack", level));
    end while ((on_output ? out_req : in_ack) !== level);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    in_req  <= 1'b0;
    out_ack <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      // First edge still shows the pre-reset state
      if (i > 0) begin
        assert (!in_ack && !out_req) else
          report_failure($sformatf("Handshake outputs high during reset in %s", test_name));
      end
    end
    rst_n <= 1'b1;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      model_taps[k] = '0;
    end
    exp_q.delete();
    @(posedge clk);
    assert (!in_ack && !out_req) else
      report_failure($sformatf("Handshake outputs high after reset in %s", test_name));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Source and sink
  //////////////////////////////////////////////////////////////////////

  // Four-phase input transfers with random idle gaps
  task automatic source(input int n, input bit full);
    int      gap;
    sample_t s;
    for (int i = 0; i < n; i++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      s = pick_sample(full);
      exp_q.push_back(model_step(s));
      in_data <= s;
      in_req  <= 1'b1;
      wait_level(1'b0, 1'b1);
      in_req <= 1'b0;
      wait_level(1'b0, 1'b0);
    end
  endtask

  // Output transfers with out_ack held back 0 to 7 cycles
  task automatic sink(input int n);
    acc_t exp;
    int   hold;
    for (int i = 0; i < n; i++) begin
      wait_level(1'b1, 1'b1);
      assert (exp_q.size() > 0) else
        report_failure($sformatf("Output in %s with no sample pending", test_name));
      exp = exp_q.pop_front();
      assert (out_data === exp) else report_failure($sformatf(
        "[ERROR] %s output %0d expected %0d actual %0d", test_name, out_count, exp, out_data));
      out_count++;
      hold = $unsigned($random(seed)) % 8;
      repeat (hold) @(posedge clk);
      out_ack <= 1'b1;
      wait_level(1'b1, 1'b0);
      out_ack <= 1'b0;
    end
  endtask

  task automatic run_stream(input int n, input bit full);
    draw_coefs(full);
    out_count = 0;
    fork
      source(n, full);
      sink(n);
    join
    // No extra result may follow the last one
    repeat (10) begin
      @(posedge clk);
      assert (!out_req) else
        report_failure($sformatf("Duplicate output after stream end in %s", test_name));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    in_req  = 1'b0;
    out_ack = 1'b0;
    in_data = '0;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      coef[k] = '0;
    end
    // First outputs see zeros in the older taps
    test_name = "reset_state";
    apply_reset();
    run_stream(`FIR_TAPS - 1, 1'b0);
    test_name = "random_stream";
    run_stream(200, 1'b0);
    test_name = "back_pressure";
    run_stream(60, 1'b0);
    // Extremes exercise the sign extension and tree wrap
    test_name = "full_scale";
    run_stream(40, 1'b1);
    test_name = "mid_stream_reset";
    apply_reset();
    run_stream(20, 1'b0);
    $display("PASS: all tests");
    $finish;
  end

endmodule : fir_wallace_tb

`default_nettype wire
